//--- verilog/swarm_pkg.sv
package swarm_pkg;

   // --------------------
   // Sizes
   // --------------------
   localparam int N_THREADS         = 8;
   localparam int LOG_CQ_SLICE_SIZE = 4;
   localparam int RW_WIDTH          = 32;
   localparam int LOG_RW_WIDTH      = 5;
   localparam int LINE_WIDTH        = 512;
   localparam int MEM_LINES         = 64;
   localparam int OUT_FIFO_DEPTH    = 8;
   localparam int RD_QUEUE_DEPTH    = 4;   // Outstanding line reads
   localparam int LOG_LOG_DEPTH     = 4;

   // --------------------
   // Register map
   // --------------------
   localparam logic [15:0] RW_BASE_ADDR                        = 16'h0010;
   localparam logic [15:0] CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD = 16'h0014;
   localparam logic [15:0] CORE_N_DEQUEUES                     = 16'h0018;
   localparam logic [15:0] DEBUG_CAPACITY                      = 16'h001c;
   localparam logic [15:0] LOG_DATA_BASE                       = 16'h0040;   // 16-aligned

   localparam logic [3:0] TASK_TYPE_NORMAL           = 4'd0;
   localparam logic [3:0] TASK_TYPE_UNDO_LOG_RESTORE = 4'd1;

   // --------------------
   // Types
   // --------------------
   typedef logic [2:0]                  thread_id_t;
   typedef logic [LOG_CQ_SLICE_SIZE-1:0] cq_slot_t;
   typedef logic [5:0]                  cache_addr_t;
   typedef logic [3:0]                  fifo_size_t;
   typedef logic [RW_WIDTH-1:0]         object_t;
   typedef logic [LINE_WIDTH-1:0]       line_t;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
      logic [3:0]  ttype;
      logic        no_read;
   } task_t;

   typedef struct packed {
      task_t       task_desc;
      cq_slot_t    cq_slot;
      thread_id_t  thread;
      object_t     object;
      cache_addr_t cache_addr;
   } rw_write_t;

   typedef struct packed {
      cache_addr_t index;
      thread_id_t  id;
   } rd_req_t;

   typedef struct packed {
      logic        wvalid;
      logic [15:0] waddr;
      logic [31:0] wdata;
   } reg_wr_t;

   typedef struct packed {
      logic        arvalid;
      logic [15:0] araddr;
   } reg_rd_req_t;

   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
   } reg_rd_rsp_t;

   typedef struct packed {
      logic        is_emit;   // 0 accept, 1 emit
      thread_id_t  thread;
      cq_slot_t    cq_slot;
      logic [15:0] locale;
      logic [15:0] object;
   } log_entry_t;

   typedef struct packed {
      logic        valid;
      cache_addr_t index;
      line_t       data;
   } mem_load_t;

endpackage

//--- verilog/rw_fifo.sv
`timescale 1ns/100ps

module rw_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = 8
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  wr_valid,
   input  T                      wr_data,
   output logic                  full,
   output logic                  rd_valid,
   input  logic                  rd_ready,
   output T                      rd_data,
   output swarm_pkg::fifo_size_t occ
);

   T mem [0:DEPTH-1];

   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;
   logic                     do_wr;
   logic                     do_rd;

   assign full     = (occ == swarm_pkg::fifo_size_t'(DEPTH));
   assign rd_valid = (occ != '0);
   assign do_wr    = wr_valid & ~full;   // Writes while full are dropped
   assign do_rd    = rd_valid & rd_ready;
   assign rd_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ    <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         occ <= occ + swarm_pkg::fifo_size_t'(do_wr) - swarm_pkg::fifo_size_t'(do_rd);
      end
   end

endmodule

//--- verilog/rw_read_regs.sv
`timescale 1ns/100ps

module rw_read_regs (
   input  logic                               clk,
   input  logic                               rstn,
   input  swarm_pkg::reg_wr_t                 reg_wr,
   input  swarm_pkg::reg_rd_req_t             reg_rd_req,
   output swarm_pkg::reg_rd_rsp_t             reg_rd_rsp,
   input  logic                               dequeue_pulse,
   input  swarm_pkg::fifo_size_t              task_out_fifo_occ,
   input  logic [swarm_pkg::LOG_LOG_DEPTH:0]  log_size,
   output logic [swarm_pkg::LOG_LOG_DEPTH-1:0] log_raddr,
   input  swarm_pkg::log_entry_t              log_rdata,
   output logic [31:0]                        base_rw_addr,
   output swarm_pkg::fifo_size_t              fifo_out_almost_full_thresh,
   output logic                               dequeue_allowed
);

   logic [31:0] dequeues_remaining;
   logic        wr_budget;
   logic        is_log_addr;
   logic [31:0] rd_word;
   logic        rsp_valid;
   logic [31:0] rsp_data;

   assign wr_budget       = reg_wr.wvalid & (reg_wr.waddr == swarm_pkg::CORE_N_DEQUEUES);
   assign dequeue_allowed = (dequeues_remaining != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_rw_addr                <= '0;
         fifo_out_almost_full_thresh <= '1;
         dequeues_remaining          <= '1;
      end else begin
         if (reg_wr.wvalid & (reg_wr.waddr == swarm_pkg::RW_BASE_ADDR)) begin
            base_rw_addr <= {reg_wr.wdata[31:2], 2'b00};   // Word aligned
         end
         if (reg_wr.wvalid & (reg_wr.waddr == swarm_pkg::CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD)) begin
            fifo_out_almost_full_thresh <= reg_wr.wdata[3:0];
         end
         if (wr_budget) begin
            dequeues_remaining <= reg_wr.wdata;
         end else if (dequeue_pulse) begin
            dequeues_remaining <= dequeues_remaining - 1'b1;
         end
      end
   end

   // --------------------
   // Read side
   // --------------------
   assign log_raddr   = reg_rd_req.araddr[swarm_pkg::LOG_LOG_DEPTH-1:0];
   assign is_log_addr = (reg_rd_req.araddr >> swarm_pkg::LOG_LOG_DEPTH) ==
                        (swarm_pkg::LOG_DATA_BASE >> swarm_pkg::LOG_LOG_DEPTH);

   always_comb begin
      rd_word = '0;
      case (reg_rd_req.araddr)
         swarm_pkg::RW_BASE_ADDR: rd_word = base_rw_addr;
         // Occupancy rides in the upper half
         swarm_pkg::CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD:
            rd_word = {12'd0, task_out_fifo_occ, 12'd0, fifo_out_almost_full_thresh};
         swarm_pkg::CORE_N_DEQUEUES: rd_word = dequeues_remaining;
         swarm_pkg::DEBUG_CAPACITY:  rd_word = 32'(log_size);
         default: begin
            if (is_log_addr) begin
               // Locale cut to 8 bits to fit one bus word
               rd_word = {log_rdata.is_emit, log_rdata.thread, log_rdata.cq_slot,
                          log_rdata.locale[7:0], log_rdata.object};
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= reg_rd_req.arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_rd_req.arvalid) begin
         rsp_data <= rd_word;
      end
   end

   assign reg_rd_rsp = '{rvalid: rsp_valid, rdata: rsp_data};

endmodule

//--- verilog/rw_read_stage.sv
`timescale 1ns/100ps

module rw_read_stage (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   task_in_valid,
   output logic                   task_in_ready,
   input  swarm_pkg::task_t       task_in,
   input  swarm_pkg::cq_slot_t    cq_slot_in,
   input  swarm_pkg::thread_id_t  thread_id_in,
   input  logic                   gvt_task_slot_valid,
   input  swarm_pkg::cq_slot_t    gvt_task_slot,
   input  logic [31:0]            base_rw_addr,
   input  swarm_pkg::fifo_size_t  fifo_out_almost_full_thresh,
   input  logic                   dequeue_allowed,
   output logic                   dequeue_pulse,
   output logic                   arvalid,
   input  logic                   arready,
   output logic [31:0]            araddr,
   output swarm_pkg::thread_id_t  arid,
   input  logic                   rvalid,
   output logic                   rready,
   input  swarm_pkg::thread_id_t  rid,
   input  swarm_pkg::line_t       rdata,
   input  swarm_pkg::cache_addr_t rindex,
   output logic                   task_out_valid,
   input  logic                   task_out_ready,
   output swarm_pkg::rw_write_t   task_out,
   input  swarm_pkg::fifo_size_t  task_out_fifo_occ,
   output logic                   log_valid,
   output swarm_pkg::log_entry_t  log_entry
);

   swarm_pkg::task_t    task_desc    [0:swarm_pkg::N_THREADS-1];
   swarm_pkg::cq_slot_t task_cq_slot [0:swarm_pkg::N_THREADS-1];
   swarm_pkg::object_t  undo_log     [0:2**swarm_pkg::LOG_CQ_SLICE_SIZE-1];

   logic                  is_restore;
   logic                  needs_read;
   logic                  can_dequeue;
   logic                  accept;
   logic                  emit;
   swarm_pkg::task_t      rd_desc;

   logic                  restore_valid;
   swarm_pkg::task_t      restore_task;
   swarm_pkg::cq_slot_t   restore_slot;
   swarm_pkg::thread_id_t restore_thread;
   swarm_pkg::object_t    restore_word;

   // --------------------
   // Acceptance
   // --------------------
   assign is_restore = (task_in.ttype == swarm_pkg::TASK_TYPE_UNDO_LOG_RESTORE);
   assign needs_read = ~task_in.no_read & ~is_restore;   // Restores never touch memory

   assign arid   = thread_id_in;
   assign araddr = base_rw_addr + (task_in.locale << (swarm_pkg::LOG_RW_WIDTH - 3));

   // Accept and emit never share a cycle, one log entry each
   assign can_dequeue = dequeue_allowed & ~task_out_valid &
      ((task_out_fifo_occ < fifo_out_almost_full_thresh) |
       (gvt_task_slot_valid & (gvt_task_slot == cq_slot_in)));

   assign arvalid       = task_in_valid & can_dequeue & needs_read;
   assign task_in_ready = task_in_valid & can_dequeue & (~needs_read | arready);
   assign accept        = task_in_valid & task_in_ready;
   assign dequeue_pulse = accept;
   assign emit          = task_out_valid & task_out_ready;

   always_ff @(posedge clk) begin
      if (accept & needs_read) begin
         task_desc[thread_id_in]    <= task_in;
         task_cq_slot[thread_id_in] <= cq_slot_in;
      end
      if (emit) begin
         undo_log[task_out.cq_slot] <= task_out.object;
      end
      if (accept & is_restore) begin
         restore_task   <= task_in;
         restore_slot   <= cq_slot_in;
         restore_thread <= thread_id_in;
         restore_word   <= undo_log[cq_slot_in];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         restore_valid <= 1'b0;
      end else if (accept & is_restore) begin
         restore_valid <= 1'b1;
      end else if (task_out_ready) begin
         restore_valid <= 1'b0;   // Restore always wins the output
      end
   end

   // --------------------
   // Output select
   // --------------------
   assign rd_desc = task_desc[rid];

   always_comb begin
      task_out.task_desc  = rd_desc;
      task_out.cq_slot    = task_cq_slot[rid];
      task_out.thread     = rid;
      task_out.object     = rdata[rd_desc.locale[3:0] * swarm_pkg::RW_WIDTH +: swarm_pkg::RW_WIDTH];
      task_out.cache_addr = rindex;
      task_out_valid      = 1'b0;
      rready              = 1'b0;
      if (restore_valid) begin
         task_out.task_desc  = restore_task;
         task_out.cq_slot    = restore_slot;
         task_out.thread     = restore_thread;
         task_out.object     = restore_word;
         task_out.cache_addr = '0;
         task_out_valid      = 1'b1;
      end else if (rvalid) begin
         task_out_valid = 1'b1;
         rready         = task_out_ready;
      end
   end

   always_comb begin
      log_valid         = accept | emit;
      log_entry.is_emit = emit;
      if (emit) begin
         log_entry.thread  = task_out.thread;
         log_entry.cq_slot = task_out.cq_slot;
         log_entry.locale  = task_out.task_desc.locale[15:0];
         log_entry.object  = task_out.object[15:0];
      end else begin
         log_entry.thread  = thread_id_in;
         log_entry.cq_slot = cq_slot_in;
         log_entry.locale  = task_in.locale[15:0];
         log_entry.object  = '0;
      end
   end

endmodule

//--- verilog/rw_line_mem.sv
`timescale 1ns/100ps

module rw_line_mem (
   input  logic                   clk,
   input  logic                   rstn,
   input  swarm_pkg::mem_load_t   mem_load,
   input  logic                   arvalid,
   output logic                   arready,
   input  logic [31:0]            araddr,
   input  swarm_pkg::thread_id_t  arid,
   output logic                   rvalid,
   input  logic                   rready,
   output swarm_pkg::thread_id_t  rid,
   output swarm_pkg::line_t       rdata,
   output swarm_pkg::cache_addr_t rindex
);

   swarm_pkg::line_t lines [0:swarm_pkg::MEM_LINES-1];

   swarm_pkg::rd_req_t req_in;
   swarm_pkg::rd_req_t req_head;
   logic               q_full;
   logic               q_valid;
   logic               line_ok;   // rdata holds the line of the head

   assign req_in  = '{index: araddr[11:6], id: arid};
   assign arready = ~q_full;

   rw_fifo #(
      .T     (swarm_pkg::rd_req_t),
      .DEPTH (swarm_pkg::RD_QUEUE_DEPTH)
   ) req_q_i (
      .clk      (clk),
      .rstn     (rstn),
      .wr_valid (arvalid),
      .wr_data  (req_in),
      .full     (q_full),
      .rd_valid (q_valid),
      .rd_ready (rvalid & rready),
      .rd_data  (req_head),
      .occ      ()
   );

   always_ff @(posedge clk) begin
      if (mem_load.valid) begin
         lines[mem_load.index] <= mem_load.data;
      end
      rdata <= lines[req_head.index];
   end

   // After a pop the next head needs one cycle to load
   always_ff @(posedge clk) begin
      if (!rstn) begin
         line_ok <= 1'b0;
      end else begin
         line_ok <= q_valid & ~(rvalid & rready);
      end
   end

   assign rvalid = q_valid & line_ok;
   assign rid    = req_head.id;
   assign rindex = req_head.index;

endmodule

//--- verilog/rw_event_log.sv
`timescale 1ns/100ps

module rw_event_log (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic                                log_valid,
   input  swarm_pkg::log_entry_t               log_entry,
   input  logic [swarm_pkg::LOG_LOG_DEPTH-1:0] log_raddr,
   output swarm_pkg::log_entry_t               log_rdata,
   output logic [swarm_pkg::LOG_LOG_DEPTH:0]   log_size
);

   swarm_pkg::log_entry_t ring [0:2**swarm_pkg::LOG_LOG_DEPTH-1];

   logic [swarm_pkg::LOG_LOG_DEPTH-1:0] wr_ptr;

   always_ff @(posedge clk) begin
      if (log_valid) begin
         ring[wr_ptr] <= log_entry;   // Oldest entry overwritten
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr   <= '0;
         log_size <= '0;
      end else if (log_valid) begin
         wr_ptr <= wr_ptr + 1'b1;
         if (!log_size[swarm_pkg::LOG_LOG_DEPTH]) begin
            log_size <= log_size + 1'b1;   // Saturates at full depth
         end
      end
   end

   assign log_rdata = ring[log_raddr];

endmodule

//--- verilog/rw_read_top.sv
`timescale 1ns/100ps

module rw_read_top (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   task_in_valid,
   output logic                   task_in_ready,
   input  swarm_pkg::task_t       task_in,
   input  swarm_pkg::cq_slot_t    cq_slot_in,
   input  swarm_pkg::thread_id_t  thread_id_in,
   input  logic                   gvt_task_slot_valid,
   input  swarm_pkg::cq_slot_t    gvt_task_slot,
   output logic                   task_out_valid,
   input  logic                   task_out_ready,
   output swarm_pkg::rw_write_t   task_out,
   input  swarm_pkg::reg_wr_t     reg_wr,
   input  swarm_pkg::reg_rd_req_t reg_rd_req,
   output swarm_pkg::reg_rd_rsp_t reg_rd_rsp,
   input  swarm_pkg::mem_load_t   mem_load
);

   logic                   arvalid;
   logic                   arready;
   logic [31:0]            araddr;
   swarm_pkg::thread_id_t  arid;
   logic                   rvalid;
   logic                   rready;
   swarm_pkg::thread_id_t  rid;
   swarm_pkg::line_t       rdata;
   swarm_pkg::cache_addr_t rindex;

   logic                   stage_out_valid;
   swarm_pkg::rw_write_t   stage_out;
   logic                   out_fifo_full;
   swarm_pkg::fifo_size_t  out_fifo_occ;

   logic [31:0]            base_rw_addr;
   swarm_pkg::fifo_size_t  fifo_out_almost_full_thresh;
   logic                   dequeue_allowed;
   logic                   dequeue_pulse;

   logic                                log_valid;
   swarm_pkg::log_entry_t               log_entry;
   logic [swarm_pkg::LOG_LOG_DEPTH:0]   log_size;
   logic [swarm_pkg::LOG_LOG_DEPTH-1:0] log_raddr;
   swarm_pkg::log_entry_t               log_rdata;

   rw_read_stage stage_i (
      .clk, .rstn,
      .task_in_valid, .task_in_ready, .task_in, .cq_slot_in, .thread_id_in,
      .gvt_task_slot_valid, .gvt_task_slot,
      .base_rw_addr, .fifo_out_almost_full_thresh, .dequeue_allowed, .dequeue_pulse,
      .arvalid, .arready, .araddr, .arid,
      .rvalid, .rready, .rid, .rdata, .rindex,
      .task_out_valid    (stage_out_valid),
      .task_out_ready    (~out_fifo_full),
      .task_out          (stage_out),
      .task_out_fifo_occ (out_fifo_occ),
      .log_valid, .log_entry
   );

   rw_read_regs regs_i (
      .clk, .rstn, .reg_wr, .reg_rd_req, .reg_rd_rsp, .dequeue_pulse,
      .task_out_fifo_occ (out_fifo_occ),
      .log_size, .log_raddr, .log_rdata,
      .base_rw_addr, .fifo_out_almost_full_thresh, .dequeue_allowed
   );

   rw_line_mem mem_i (
      .clk, .rstn, .mem_load,
      .arvalid, .arready, .araddr, .arid,
      .rvalid, .rready, .rid, .rdata, .rindex
   );

   rw_fifo #(
      .T     (swarm_pkg::rw_write_t),
      .DEPTH (swarm_pkg::OUT_FIFO_DEPTH)
   ) out_fifo_i (
      .clk      (clk),
      .rstn     (rstn),
      .wr_valid (stage_out_valid),
      .wr_data  (stage_out),
      .full     (out_fifo_full),
      .rd_valid (task_out_valid),
      .rd_ready (task_out_ready),
      .rd_data  (task_out),
      .occ      (out_fifo_occ)
   );

   rw_event_log log_i (
      .clk, .rstn, .log_valid, .log_entry, .log_raddr, .log_rdata, .log_size
   );

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   initial begin
      rstn = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

//--- tb/rw_read_chk.sv
`timescale 1ns/100ps

module rw_read_chk (
   input logic clk,
   input logic rstn,
   input logic arvalid,
   input logic dequeue_allowed,
   input logic rvalid,
   input logic rready,
   input logic task_out_valid
);

   // No read request without budget
   assert property (@(posedge clk) disable iff (!rstn) !dequeue_allowed |-> !arvalid)
      else $error("read request issued with a zero dequeue budget");

   assert property (@(posedge clk) disable iff (!rstn) rready |-> rvalid)
      else $error("rready high without rvalid");

   // First cycle out of reset
   assert property (@(posedge clk) $rose(rstn) |-> !task_out_valid)
      else $error("task_out_valid high right after reset");

endmodule

//--- tb/rw_read_tb.sv
`timescale 1ns/100ps

module rw_read_tb;

   typedef struct packed {
      logic [3:0]            ttype;
      logic                  no_read;
      logic [31:0]           locale;
      swarm_pkg::cq_slot_t   slot;
      swarm_pkg::thread_id_t thread;
   } row_t;

   localparam int N_ROWS   = 12;
   localparam int LOG_RUNS = 8;   // Serialized reads that refill the whole log
   localparam int LIMIT    = 40 * (N_ROWS + LOG_RUNS) + 4 * swarm_pkg::MEM_LINES;

   logic                   clk;
   logic                   rstn;
   logic                   task_in_valid;
   logic                   task_in_ready;
   swarm_pkg::task_t       task_in;
   swarm_pkg::cq_slot_t    cq_slot_in;
   swarm_pkg::thread_id_t  thread_id_in;
   logic                   gvt_task_slot_valid;
   swarm_pkg::cq_slot_t    gvt_task_slot;
   logic                   task_out_valid;
   logic                   task_out_ready;
   swarm_pkg::rw_write_t   task_out;
   swarm_pkg::reg_wr_t     reg_wr;
   swarm_pkg::reg_rd_req_t reg_rd_req;
   swarm_pkg::reg_rd_rsp_t reg_rd_rsp;
   swarm_pkg::mem_load_t   mem_load;

   swarm_pkg::object_t   mem_model [0:swarm_pkg::MEM_LINES-1][0:15];
   swarm_pkg::object_t   undo_model [0:15];
   swarm_pkg::rw_write_t exp_q [$];
   swarm_pkg::rw_write_t mon_exp;
   row_t                 rows [0:N_ROWS-1];
   logic [31:0]          log_words [$];
   logic [31:0]          base;
   logic [31:0]          lcg_state;
   int                   n_accepts;
   int                   n_outputs;
   int                   cycles;

   tb_clkgen clkgen_i (.clk, .rstn);

   rw_read_top dut_i (.*);

   bind rw_read_stage rw_read_chk chk_i (.*);

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic check_write(input swarm_pkg::rw_write_t got, input swarm_pkg::rw_write_t exp);
      if (got !== exp) begin
         fail_now($sformatf("mismatch task_out exp %h got %h", exp, got));
      end
   endtask

   task automatic check_reg(input string name, input swarm_pkg::object_t got,
                            input swarm_pkg::object_t exp);
      if (got !== exp) begin
         fail_now($sformatf("mismatch %s exp %h got %h", name, exp, got));
      end
   endtask

   // --------------------
   // Bus helpers
   // --------------------
   task automatic preload_mem();
      swarm_pkg::line_t line;
      for (int l = 0; l < swarm_pkg::MEM_LINES; l++) begin
         for (int w = 0; w < 16; w++) begin
            lcg_state       = lcg_next(lcg_state);
            mem_model[l][w] = lcg_state;
            line[w*32 +: 32] = lcg_state;
         end
         mem_load = '{valid: 1'b1, index: swarm_pkg::cache_addr_t'(l), data: line};
         @(negedge clk);
      end
      mem_load.valid = 1'b0;
   endtask

   task automatic reg_write(input logic [15:0] a, input logic [31:0] d);
      reg_wr = '{wvalid: 1'b1, waddr: a, wdata: d};
      @(negedge clk);
      reg_wr.wvalid = 1'b0;
   endtask

   task automatic reg_read(input logic [15:0] a, output logic [31:0] d);
      reg_rd_req = '{arvalid: 1'b1, araddr: a};
      @(negedge clk);
      reg_rd_req.arvalid = 1'b0;
      if (!reg_rd_rsp.rvalid) begin
         fail_now("no register response one cycle after the read request");
      end
      d = reg_rd_rsp.rdata;
   endtask

   task automatic present_task(input swarm_pkg::task_t t, input swarm_pkg::cq_slot_t s,
                               input swarm_pkg::thread_id_t th);
      task_in       = t;
      cq_slot_in    = s;
      thread_id_in  = th;
      task_in_valid = 1'b1;
   endtask

   task automatic wait_accept();
      #1;
      while (!task_in_ready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);   // Taken at the posedge in between
      task_in_valid = 1'b0;
      n_accepts++;
   endtask

   task automatic expect_stall(input int n, input string what);
      repeat (n) begin
         #1;
         if (task_in_ready) begin
            fail_now($sformatf("task accepted although %s", what));
         end
         @(negedge clk);
      end
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
   endtask

   // --------------------
   // Reference model
   // --------------------
   function automatic swarm_pkg::task_t make_task(input row_t r, input logic [31:0] ts);
      return '{ts: ts, locale: r.locale, ttype: r.ttype, no_read: r.no_read};
   endfunction

   function automatic swarm_pkg::rw_write_t expect_read(input row_t r, input logic [31:0] ts);
      swarm_pkg::rw_write_t e;
      logic [31:0]          addr;
      addr         = base + (r.locale << 2);
      e.task_desc  = make_task(r, ts);
      e.cq_slot    = r.slot;
      e.thread     = r.thread;
      e.object     = mem_model[addr[11:6]][r.locale[3:0]];
      e.cache_addr = addr[11:6];
      return e;
   endfunction

   task automatic drive_row(input row_t r, input logic [31:0] ts);
      swarm_pkg::rw_write_t e;
      if (r.ttype == swarm_pkg::TASK_TYPE_UNDO_LOG_RESTORE) begin
         drain();   // Undo log must hold the last emitted object
         e.task_desc  = make_task(r, ts);
         e.cq_slot    = r.slot;
         e.thread     = r.thread;
         e.object     = undo_model[r.slot];
         e.cache_addr = '0;
         exp_q.push_back(e);
      end else if (!r.no_read) begin
         exp_q.push_back(expect_read(r, ts));
      end
      present_task(make_task(r, ts), r.slot, r.thread);
      wait_accept();
   endtask

   // Output monitor, sampled away from the clock edge
   always begin
      @(negedge clk);
      #1;
      if (rstn && task_out_valid && task_out_ready) begin
         if (exp_q.size() == 0) begin
            fail_now("unexpected task output with no task pending");
         end else begin
            mon_exp = exp_q.pop_front();
            check_write(task_out, mon_exp);
            undo_model[mon_exp.cq_slot] = mon_exp.object;
            n_outputs++;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         fail_now($sformatf("timeout after %0d cycles", cycles));
      end
   end

   initial begin
      logic [31:0]          rd;
      row_t                 r;
      swarm_pkg::rw_write_t e;
      int                   base_idx;
      int                   total;
      task_in_valid       = 1'b0;
      task_in             = '0;
      cq_slot_in          = '0;
      thread_id_in        = '0;
      gvt_task_slot_valid = 1'b0;
      gvt_task_slot       = '0;
      task_out_ready      = 1'b0;
      reg_wr              = '0;
      reg_rd_req          = '0;
      mem_load            = '0;
      lcg_state           = 32'd77;
      n_accepts           = 0;
      n_outputs           = 0;
      cycles              = 0;

      rows[0]  = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h003, 4'd1, 3'd0};
      rows[1]  = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h025, 4'd2, 3'd1};
      rows[2]  = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b1, 32'h040, 4'd3, 3'd2};
      rows[3]  = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h1a7, 4'd4, 3'd3};
      rows[4]  = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h00f, 4'd5, 3'd4};
      rows[5]  = '{swarm_pkg::TASK_TYPE_UNDO_LOG_RESTORE, 1'b0, 32'h000, 4'd2, 3'd5};
      rows[6]  = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h3c4, 4'd2, 3'd6};
      rows[7]  = '{swarm_pkg::TASK_TYPE_UNDO_LOG_RESTORE, 1'b0, 32'h000, 4'd2, 3'd7};
      rows[8]  = '{swarm_pkg::TASK_TYPE_UNDO_LOG_RESTORE, 1'b0, 32'h000, 4'd4, 3'd0};
      rows[9]  = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h07e, 4'd6, 3'd1};
      rows[10] = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h012, 4'd7, 3'd2};
      rows[11] = '{swarm_pkg::TASK_TYPE_UNDO_LOG_RESTORE, 1'b0, 32'h000, 4'd1, 3'd3};

      wait (rstn);
      @(negedge clk);
      preload_mem();
      base = 32'h0000_0840;
      reg_write(swarm_pkg::RW_BASE_ADDR, base);
      task_out_ready = 1'b1;

      // --------------------
      // Table of reads, no_read and restores
      // --------------------
      for (int i = 0; i < N_ROWS; i++) begin
         drive_row(rows[i], 32'h1000 + i);
      end
      drain();

      // Budget runs out after two
      reg_write(swarm_pkg::CORE_N_DEQUEUES, 32'd5);
      reg_read(swarm_pkg::CORE_N_DEQUEUES, rd);
      check_reg("n_dequeues", rd, 32'd5);
      reg_write(swarm_pkg::CORE_N_DEQUEUES, 32'd2);
      r = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b1, 32'h011, 4'd0, 3'd0};
      drive_row(r, 32'h2000);
      drive_row(r, 32'h2001);
      r.no_read = 1'b0;   // A read task must not issue either
      present_task(make_task(r, 32'h2002), r.slot, r.thread);
      expect_stall(10, "the dequeue budget is zero");
      task_in_valid = 1'b0;
      reg_write(swarm_pkg::CORE_N_DEQUEUES, 32'hffff_ffff);

      // --------------------
      // Threshold stall and commit slot bypass
      // --------------------
      reg_write(swarm_pkg::CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD, 32'd1);
      reg_read(swarm_pkg::CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD, rd);
      check_reg("threshold", rd, 32'h0000_0001);
      task_out_ready = 1'b0;
      r = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h055, 4'd8, 3'd0};
      drive_row(r, 32'h3000);
      while (!task_out_valid) begin
         @(negedge clk);
      end
      r = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h0a3, 4'd9, 3'd1};
      exp_q.push_back(expect_read(r, 32'h3001));
      present_task(make_task(r, 32'h3001), r.slot, r.thread);
      expect_stall(8, "the output FIFO is at the threshold");
      gvt_task_slot       = 4'd9;
      gvt_task_slot_valid = 1'b1;
      wait_accept();
      gvt_task_slot_valid = 1'b0;
      task_out_ready      = 1'b1;
      drain();
      reg_write(swarm_pkg::CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD, 32'hf);

      // --------------------
      // Serialized reads fill the log with a known order
      // --------------------
      base_idx = (n_accepts + n_outputs) % 16;
      for (int k = 0; k < LOG_RUNS; k++) begin
         r = '{swarm_pkg::TASK_TYPE_NORMAL, 1'b0, 32'h20 + 32'(k * 5),
               swarm_pkg::cq_slot_t'(k + 8), swarm_pkg::thread_id_t'(k)};
         e = expect_read(r, 32'h4000 + k);
         exp_q.push_back(e);
         present_task(e.task_desc, r.slot, r.thread);
         wait_accept();
         drain();
         log_words.push_back({1'b0, r.thread, r.slot, r.locale[7:0], 16'h0});
         log_words.push_back({1'b1, e.thread, e.cq_slot, e.task_desc.locale[7:0],
                              e.object[15:0]});
      end

      total = n_accepts + n_outputs;
      reg_read(swarm_pkg::DEBUG_CAPACITY, rd);
      check_reg("log_size", rd, (total > 16) ? 32'd16 : 32'(total));
      for (int k = 0; k < 16; k++) begin
         reg_read(swarm_pkg::LOG_DATA_BASE + 16'((base_idx + k) % 16), rd);
         check_reg($sformatf("log_entry[%0d]", (base_idx + k) % 16), rd, log_words[k]);
      end

      if (exp_q.size() != 0) begin
         fail_now("expected task outputs never arrived");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule

//--- tb.f
verilog/swarm_pkg.sv
verilog/rw_fifo.sv
verilog/rw_read_regs.sv
verilog/rw_read_stage.sv
verilog/rw_line_mem.sv
verilog/rw_event_log.sv
verilog/rw_read_top.sv
tb/tb_clkgen.sv
tb/rw_read_chk.sv
tb/rw_read_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rw_read_tb
FILELIST  = tb.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q 'TEST FAILED' $(LOG); then exit 1; fi
	@grep -q 'TEST PASSED' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
